//--- ps2_rx_cases.txt
// columns: op _ byte _ corrupt _ scan_en _ expected error after the op
// op 1 send, 2 drain <byte> reads, 3 clear error, 4 burst of <byte> random frames, f end
// corrupt 0 none, 1 flipped parity, 2 stop bit low
1_1c_0_1_0  // single good frame
2_01_0_1_0
1_32_0_1_0  // three frames queued before any read
1_5a_0_1_0
1_f0_0_1_0
2_03_0_1_0
1_a5_1_1_1  // parity error
3_00_0_1_0
1_3c_2_1_1  // stop bit error
3_00_0_1_0
4_05_0_1_1  // five into four entries, the last is dropped
2_04_0_1_1
3_00_0_1_0
1_77_0_0_0  // scan disabled, dropped quietly
2_01_0_1_0  // read on an empty FIFO
1_81_0_1_0
2_02_0_1_0  // one byte, then an empty read
f_00_0_0_0

//--- flist.f
+incdir+.
ps2_pkg.sv
ps2_frame_if.sv
ps2_frame_shift.sv
ps2_frame_sync.sv
ps2_rx_fifo.sv
ps2_kbd_rx.sv
ps2_rx_checker.sv
tb_ps2_kbd_rx.sv

//--- Makefile
# Verilator build and run of the PS/2 receive path testbench

VERILATOR ?= verilator
TOP       ?= tb_ps2_kbd_rx
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All checks passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail, not the simulator's exit status
run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -x "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_ps2_kbd_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

module tb_ps2_kbd_rx;

    localparam int MAX_CASES = 64;
    localparam int KBD_HALF  = 50;                      // kbd_clk half period in ns
    localparam int SETTLE    = `PS2_SYNC_STAGES + 2;    // sync flops, push, data_ready
    localparam int FRAME_NS  = 1200;                    // one frame plus settling, rounded up

    logic                      core_clk;
    logic                      rst_n;
    logic                      kbd_clk;
    logic                      kbd_data;
    logic                      scan_en;
    logic                      read_en;
    logic                      err_clr;
    logic [`PS2_DATA_BITS-1:0] data_out;
    logic                      valid;
    logic                      data_ready;
    logic                      error;

    logic [23:0] cases [MAX_CASES];     // op, byte, corrupt, scan_en, expected error
    logic [31:0] rng_state;
    int          file_errs = 0;

    initial core_clk = 1'b0;
    always #5 core_clk = ~core_clk;

    ps2_kbd_rx uut (
        .kbd_clk    (kbd_clk),
        .kbd_data   (kbd_data),
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .scan_en    (scan_en),
        .read_en    (read_en),
        .err_clr    (err_clr),
        .data_out   (data_out),
        .valid      (valid),
        .data_ready (data_ready),
        .error      (error)
    );

    ps2_rx_checker chk (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .read_en    (read_en),
        .data_out   (data_out),
        .valid      (valid),
        .data_ready (data_ready),
        .error      (error)
    );

    // xorshift32
    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // corrupt 1 flips the parity bit, 2 pulls the stop bit low
    task automatic send_frame(input logic [`PS2_DATA_BITS-1:0] b, input logic [3:0] corrupt);
        logic [`PS2_FRAME_BITS-1:0] bits;
        bits = {1'b1, ~^b, b, 1'b0};                    // stop, odd parity, data, start
        if (corrupt == 4'h1) bits[`PS2_FRAME_BITS-2] = ~bits[`PS2_FRAME_BITS-2];
        if (corrupt == 4'h2) bits[`PS2_FRAME_BITS-1] = 1'b0;
        @(posedge core_clk);
        #2;                                             // kbd edges never land on core edges
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            kbd_data <= bits[i];
            kbd_clk  <= 1'b0;
            #KBD_HALF;
            kbd_clk  <= 1'b1;                           // sampled here
            #KBD_HALF;
        end
    endtask

    task automatic drain(input int n);
        repeat (n) begin
            @(posedge core_clk);
            read_en <= 1'b1;
            @(posedge core_clk);
            read_en <= 1'b0;
        end
    endtask

    task automatic clear_error();
        @(posedge core_clk);
        err_clr <= 1'b1;
        @(posedge core_clk);
        err_clr <= 1'b0;                                // DUT saw it on this edge
        chk.err_cleared();
    endtask

    task automatic settle_and_check(input logic exp_err);
        repeat (SETTLE) @(posedge core_clk);
        @(negedge core_clk);
        chk.check_settled(exp_err);
    endtask

    initial begin : main
        logic [3:0] op;
        logic [7:0] arg;
        logic [3:0] corrupt;
        int         n_ops;
        int         n_frames;
        int         n_reads;
        int         limit_ns;
        kbd_clk   = 1'b1;                               // idle lines high
        kbd_data  = 1'b1;
        rst_n     = 1'b0;
        scan_en   = 1'b0;
        read_en   = 1'b0;
        err_clr   = 1'b0;
        rng_state = 32'd9;
        n_ops     = 0;
        n_frames  = 0;
        n_reads   = 0;
        $readmemh("ps2_rx_cases.txt", cases);
        while (n_ops < MAX_CASES && cases[n_ops][23:20] != 4'hf) begin
            op  = cases[n_ops][23:20];
            arg = cases[n_ops][19:12];
            if (op == 4'h1) n_frames++;
            if (op == 4'h4) n_frames += int'(arg);
            if (op == 4'h2) n_reads += int'(arg);
            n_ops++;
        end
        if (n_ops == 0) begin
            $display("no cases found in ps2_rx_cases.txt");
            file_errs++;
        end
        limit_ns = n_frames * FRAME_NS + n_reads * 20 + n_ops * 100 + 2000;
        fork
            begin
                #limit_ns;
                $display("timeout: run passed %0d ns before the cases finished", limit_ns);
                $display("Checks failed");
                $finish;
            end
        join_none
        repeat (2) @(posedge core_clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            op      = cases[i][23:20];
            arg     = cases[i][19:12];
            corrupt = cases[i][11:8];
            case (op)
                4'h1, 4'h4: begin
                    @(posedge core_clk);
                    scan_en <= cases[i][4];
                    repeat ((op == 4'h4) ? int'(arg) : 1) begin
                        if (op == 4'h4) begin
                            rng_state = next_rand(rng_state);
                            arg       = rng_state[7:0];
                        end
                        send_frame(arg, corrupt);
                        chk.frame_sent(arg, corrupt != 4'h0, cases[i][4]);
                    end
                end
                4'h2: drain(int'(arg));
                4'h3: clear_error();
                default: begin
                    $display("unknown operation %h on case %0d", op, i);
                    file_errs++;
                end
            endcase
            settle_and_check(cases[i][0]);
        end
        $display("checks done: %0d value errors, %0d other errors, %0d case file errors",
                 chk.value_errs, chk.other_errs, file_errs);
        if (chk.value_errs + chk.other_errs + file_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_ps2_kbd_rx

`default_nettype wire

//--- ps2_rx_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

// reference model of the receive path, seen from the core side
// holds the bytes that should be queued and the sticky error flag
module ps2_rx_checker (
    input logic                      core_clk,
    input logic                      rst_n,
    input logic                      read_en,
    input logic [`PS2_DATA_BITS-1:0] data_out,
    input logic                      valid,
    input logic                      data_ready,
    input logic                      error
);

    logic [`PS2_DATA_BITS-1:0] model_q [$];     // expected FIFO contents, head at 0
    logic                      model_err = 1'b0;
    int                        value_errs = 0;  // FAILED lines
    int                        other_errs = 0;

    // read_en moves on posedge, so valid and data_out are steady at negedge
    always @(negedge core_clk) begin : watch_reads
        logic                      exp_valid;
        logic [`PS2_DATA_BITS-1:0] head;
        if (rst_n) begin
            exp_valid = read_en & (model_q.size() != 0);
            if (valid !== exp_valid) begin
                $display("FAILED valid: got %h expected %h", valid, exp_valid);
                value_errs++;
            end
            if (exp_valid) begin
                head = model_q.pop_front();     // DUT pops on the coming posedge
                if (valid && data_out !== head) begin
                    $display("FAILED data_out: got %h expected %h", data_out, head);
                    value_errs++;
                end
            end
        end
    end

    // a whole frame went out on the keyboard lines
    task automatic frame_sent(input logic [`PS2_DATA_BITS-1:0] b, input logic bad,
                              input logic scan);
        if (bad) begin
            model_err = 1'b1;                   // dropped whatever scan_en says
        end else if (scan) begin
            if (model_q.size() < `PS2_FIFO_DEPTH) begin
                model_q.push_back(b);
            end else begin
                model_err = 1'b1;               // lost to a full FIFO
            end
        end
    endtask

    task automatic err_cleared();
        model_err = 1'b0;
    endtask

    // called once an operation has had time to reach the FIFO
    task automatic check_settled(input logic exp_err);
        logic exp_ready;
        exp_ready = (model_q.size() != 0);
        if (data_ready !== exp_ready) begin
            $display("FAILED data_ready: got %h expected %h", data_ready, exp_ready);
            value_errs++;
        end
        if (error !== model_err) begin
            $display("FAILED error: got %h expected %h", error, model_err);
            value_errs++;
        end
        if (exp_err !== model_err) begin
            $display("case file expects error %0b but the model gives %0b", exp_err, model_err);
            other_errs++;
        end
    endtask

endmodule : ps2_rx_checker

`default_nettype wire

//--- ps2_kbd_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

// PS/2 keyboard receive path
// kbd_clk side shifts frames in, core_clk side syncs them and queues the bytes
module ps2_kbd_rx (
    // keyboard lines
    input  logic                      kbd_clk,
    input  logic                      kbd_data,
    // core side
    input  logic                      core_clk,
    input  logic                      rst_n,     // shared by both domains
    input  logic                      scan_en,   // accept new bytes
    input  logic                      read_en,   // pop the head byte
    input  logic                      err_clr,
    output logic [`PS2_DATA_BITS-1:0] data_out,
    output logic                      valid,
    output logic                      data_ready,
    output logic                      error
);

    logic               fifo_full;
    logic               fifo_empty;
    logic               push;
    ps2_pkg::ps2_byte_t push_data;

    ps2_frame_if frm ();    // the only path between the two clocks

    ps2_frame_shift u_shift (
        .kbd_clk  (kbd_clk),
        .kbd_data (kbd_data),
        .rst_n    (rst_n),
        .frm      (frm.keyboard)
    );

    ps2_frame_sync u_sync (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .frm       (frm.core),
        .scan_en   (scan_en),
        .full      (fifo_full),
        .err_clr   (err_clr),
        .push      (push),
        .push_data (push_data),
        .error     (error)
    );

    ps2_rx_fifo #(
        .DEPTH (`PS2_FIFO_DEPTH),
        .WIDTH (`PS2_DATA_BITS)
    ) u_fifo (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (read_en),
        .pop_data  (data_out),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    assign valid      = ~fifo_empty & read_en;  // this read really took a byte
    assign data_ready = ~fifo_empty;

endmodule : ps2_kbd_rx

`default_nettype wire

//--- ps2_rx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

// show-ahead FIFO, head entry always on pop_data
// pop is the consumer acknowledging what it already sees
module ps2_rx_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             core_clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // pointer width
    localparam int CW = $clog2(DEPTH + 1);                  // count reaches DEPTH

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);

    assign do_push = push & ~full;  // a push into a full FIFO is lost
    assign do_pop  = pop & ~empty;  // a pop on empty does nothing

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap by compare so depths other than powers of two work
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule : ps2_rx_fifo

`default_nettype wire

//--- ps2_frame_sync.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

// brings a finished frame into core_clk
// only done goes through flops; data and bad are held steady by the keyboard
// side for many core cycles, so they are sampled directly on the done edge
module ps2_frame_sync (
    input  logic               core_clk,
    input  logic               rst_n,
    ps2_frame_if.core          frm,
    input  logic               scan_en,
    input  logic               full,
    input  logic               err_clr,
    output logic               push,
    output ps2_pkg::ps2_byte_t push_data,
    output logic               error
);

    logic [`PS2_SYNC_STAGES-1:0] sync_q;    // done level through the synchroniser
    logic                        done_prev; // synchronised done one cycle back
    logic                        done_rise; // first core cycle of a new frame
    logic                        frame_err; // parity or framing, both set the same flag
    logic                        drop_full; // good frame with nowhere to go
    logic                        take;      // good frame that goes into the FIFO
    logic                        err_set;

    assign done_rise = sync_q[`PS2_SYNC_STAGES-1] & ~done_prev;

    assign frame_err = done_rise & frm.bad;

    // scan_en low drops the byte without any complaint
    assign take      = done_rise & ~frm.bad & scan_en & ~full;
    assign drop_full = done_rise & ~frm.bad & scan_en & full;

    assign err_set = frame_err | drop_full;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q    <= '0;
            done_prev <= 1'b0;
            push      <= 1'b0;
            error     <= 1'b0;
        end else begin
            sync_q[0] <= frm.done;
            for (int i = 1; i < `PS2_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            done_prev <= sync_q[`PS2_SYNC_STAGES-1];
            push      <= take;          // lines up with push_data below
            if (err_set) begin
                error <= 1'b1;          // sticky, a new error beats the clear
            end else if (err_clr) begin
                error <= 1'b0;
            end
        end
    end

    // byte is captured on every frame edge, push decides if it is used
    always_ff @(posedge core_clk) begin
        if (done_rise) begin
            push_data <= frm.data;
        end
    end

endmodule : ps2_frame_sync

`default_nettype wire

//--- ps2_frame_shift.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

// kbd_clk domain frame assembly
// the keyboard drives the clock, so nothing here toggles while it idles
// and the reset has to be asynchronous
module ps2_frame_shift (
    input  logic          kbd_clk,
    input  logic          kbd_data,
    input  logic          rst_n,
    ps2_frame_if.keyboard frm
);

    logic [`PS2_FRAME_BITS-1:0] pos_q;      // one-hot, marks the bit sampled on the next edge
    logic [`PS2_FRAME_BITS-1:0] pos_next;
    logic [`PS2_FRAME_BITS-1:0] shift_q;    // raw frame bits, newest at the top
    logic [`PS2_FRAME_BITS-1:0] shift_next;
    logic                       last_bit;   // this edge samples the stop bit
    logic                       start_ok;
    logic                       parity_ok;
    logic                       stop_ok;

    // the valid bit walks round the frame once per kbd_clk edge
    assign pos_next = {pos_q[`PS2_FRAME_BITS-2:0], pos_q[`PS2_FRAME_BITS-1]};
    assign last_bit = pos_q[`PS2_FRAME_BITS-1];

    // shift right so the first bit on the wire ends up at the bottom
    // no bit reversal needed afterwards
    assign shift_next = {kbd_data, shift_q[`PS2_FRAME_BITS-1:1]};

    // checks look at the frame including the bit arriving on this edge
    assign start_ok  = ~shift_next[0];
    assign parity_ok = ^shift_next[`PS2_FRAME_BITS-2:1];   // 8 data + parity, odd count of ones
    assign stop_ok   = shift_next[`PS2_FRAME_BITS-1];

    always_ff @(posedge kbd_clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_q    <= {{(`PS2_FRAME_BITS-1){1'b0}}, 1'b1};  // expect the start bit first
            frm.done <= 1'b0;
            frm.bad  <= 1'b0;
        end else begin
            pos_q    <= pos_next;
            frm.done <= last_bit;       // high from the stop edge to the next start edge
            if (last_bit) begin
                frm.bad <= ~(start_ok & parity_ok & stop_ok);
            end
        end
    end

    // frame payload, only meaningful once a whole frame has been shifted in
    always_ff @(posedge kbd_clk) begin
        shift_q <= shift_next;
        if (last_bit) begin
            frm.data <= shift_next[`PS2_DATA_BITS:1];
            // a broken start or stop bit hides the parity result
            if (start_ok && stop_ok) begin
                frm.err_kind <= ps2_pkg::ERR_PARITY;
            end else begin
                frm.err_kind <= ps2_pkg::ERR_FRAMING;
            end
        end
    end

endmodule : ps2_frame_shift

`default_nettype wire

//--- ps2_frame_if.sv
`timescale 1ns/10ps
`default_nettype none

// one finished frame handed from the kbd_clk domain to the core_clk domain
// data, bad and err_kind are settled on the same kbd_clk edge that raises done
// and do not move until the next frame completes
interface ps2_frame_if;

    logic                done;      // level, rises on the stop bit edge
    ps2_pkg::ps2_byte_t  data;      // byte, first received bit in bit 0
    logic                bad;       // frame failed start, parity or stop check
    ps2_pkg::ps2_err_t   err_kind;  // which check, only meaningful with bad

    // keyboard side builds the frame
    modport keyboard (
        output done,
        output data,
        output bad,
        output err_kind
    );

    // core side only looks at it
    modport core (
        input done,
        input data,
        input bad,
        input err_kind
    );

endinterface : ps2_frame_if

`default_nettype wire

//--- ps2_pkg.sv
`default_nettype none

`include "ps2_consts.svh"

package ps2_pkg;

    // one received byte, as the keyboard sent it
    // bit 0 is the first data bit on the wire
    typedef logic [`PS2_DATA_BITS-1:0] ps2_byte_t;

    // which check a bad frame failed
    // framing covers a wrong start bit or a wrong stop bit,
    // parity is only reported when start and stop both look right
    typedef enum logic {
        ERR_PARITY  = 1'b0,     // data plus parity bit not odd
        ERR_FRAMING = 1'b1      // start not 0 or stop not 1
    } ps2_err_t;

endpackage : ps2_pkg

`default_nettype wire

//--- ps2_consts.svh
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// PS/2 device-to-host frame
// start(0) + 8 data bits lsb first + odd parity + stop(1)
`define PS2_FRAME_BITS 11

// payload bits carried in one frame
`define PS2_DATA_BITS 8

// entries in the core-side receive FIFO
// at the keyboard's rate this covers a short burst of make/break codes
`define PS2_FIFO_DEPTH 4

// flops on the done level before edge detection in core_clk
// two is enough as long as kbd_clk stays far slower than core_clk
`define PS2_SYNC_STAGES 2

// frame bit positions follow from the layout above
// start sits at bit 0, data at 1..8, parity at 9, stop at 10

`endif // PS2_CONSTS_SVH
